/* src/th_pkg.sv */
package th_pkg;

  typedef logic [15:0]  th_word_t;
  typedef logic [20:0]  th_ridx_t;
  typedef logic [111:0] th_ctrl_t;  // Seven control words, CTRL_0 lowest.

  typedef enum logic [1:0] {
    MODE_ADDR  = 2'd0,
    MODE_LFSR  = 2'd1,
    MODE_WALK  = 2'd2,
    MODE_CONST = 2'd3
  } th_mode_t;

  localparam int unsigned NUM_CTRL = 7;

  localparam th_ridx_t REG_CTRL_0 = 21'd0;  // Go and mode.
  localparam th_ridx_t REG_CTRL_1 = 21'd1;  // Base address.
  localparam th_ridx_t REG_CTRL_2 = 21'd2;  // Word count.
  localparam th_ridx_t REG_CTRL_3 = 21'd3;  // Seed.
  localparam th_ridx_t REG_CTRL_4 = 21'd4;  // Fault address.
  localparam th_ridx_t REG_CTRL_5 = 21'd5;  // Fault xor mask.
  localparam th_ridx_t REG_CTRL_6 = 21'd6;  // Fault enable.

  localparam th_ridx_t ST_FLAGS     = 21'd8;
  localparam th_ridx_t ST_ERRCNT    = 21'd9;
  localparam th_ridx_t ST_FAIL_ADDR = 21'd10;
  localparam th_ridx_t ST_FAIL_EXP  = 21'd11;
  localparam th_ridx_t ST_FAIL_ACT  = 21'd12;

  localparam int unsigned FLAG_BUSY = 0;
  localparam int unsigned FLAG_DONE = 1;
  localparam int unsigned FLAG_PASS = 2;

  localparam th_word_t LFSR_TAPS = 16'hB400;

  // Picks one 16-bit word out of the packed control vector.
  function automatic th_word_t ctrl_word(th_ctrl_t ctrl, th_ridx_t idx);
    return ctrl[16*idx +: 16];
  endfunction

endpackage

/* src/th_wb_regs.sv */
`timescale 1ns/1ps

module th_wb_regs
  import th_pkg::*;
(
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  th_word_t    wb_dat_i,
  output th_word_t    wb_dat_o,
  output logic        wb_ack_o,
  output th_ridx_t    status_addr_o,
  input  th_word_t    harness_status_i,
  output th_ctrl_t    harness_control_o
);

  th_ctrl_t ctrl_q;
  th_ridx_t rd_idx_q;
  th_ridx_t wb_idx;
  logic     access;

  assign wb_idx = wb_adr_i[21:1];  // Word index.
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      rd_idx_q <= '0;
      ctrl_q   <= '0;
    end else begin
      wb_ack_o <= access;  // One cycle per access.
      if (access) begin
        rd_idx_q <= wb_idx;
        for (int i = 0; i < NUM_CTRL; i++) begin
          if (wb_we_i && wb_idx == th_ridx_t'(i)) begin
            if (wb_sel_i[0]) begin
              ctrl_q[16*i +: 8] <= wb_dat_i[7:0];
            end
            if (wb_sel_i[1]) begin
              ctrl_q[16*i+8 +: 8] <= wb_dat_i[15:8];
            end
          end
        end
      end
    end
  end

  // Read data follows the latched index, so it is stable under ack.
  assign wb_dat_o = (rd_idx_q < NUM_CTRL) ? ctrl_word(ctrl_q, rd_idx_q) : harness_status_i;

  assign status_addr_o     = rd_idx_q;
  assign harness_control_o = ctrl_q;

endmodule

/* src/th_pattern_gen.sv */
`timescale 1ns/1ps

module th_pattern_gen
  import th_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  logic     restart_i,
  input  logic     step_i,
  input  th_mode_t mode_i,
  input  th_word_t seed_i,
  input  th_word_t addr_i,
  output th_word_t word_o
);

  th_word_t lfsr_q;
  th_word_t lfsr_next;

  // Galois form, shifting right.
  assign lfsr_next = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : th_word_t'(0));

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      lfsr_q <= '0;
    end else if (restart_i) begin
      lfsr_q <= seed_i;  // Restart wins over step.
    end else if (step_i) begin
      lfsr_q <= lfsr_next;
    end
  end

  always_comb begin
    case (mode_i)
      MODE_ADDR:  word_o = addr_i ^ seed_i;
      MODE_LFSR:  word_o = lfsr_q;
      MODE_WALK:  word_o = th_word_t'(1) << addr_i[3:0];
      MODE_CONST: word_o = seed_i;
      default:    word_o = '0;
    endcase
  end

endmodule

/* src/th_sequencer.sv */
`timescale 1ns/1ps

module th_sequencer
  import th_pkg::*;
#(
  parameter int unsigned ADDR_W = 8
) (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  th_ctrl_t          harness_control_i,
  output logic              pat_restart_o,
  output logic              pat_step_o,
  output th_word_t          pat_addr_o,
  input  th_word_t          pat_word_i,
  output logic              mem_we_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  output th_word_t          mem_wdata_o,
  input  th_word_t          mem_rdata_i,
  output logic              cmp_valid_o,
  output th_word_t          cmp_addr_o,
  output th_word_t          cmp_exp_o,
  output th_word_t          cmp_act_o,
  output logic              clear_o,
  output logic              busy_o,
  output logic              done_o
);

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    DRAIN,
    DONE
  } state_t;

  state_t            state_q;
  th_word_t          ctrl_0;
  th_word_t          count;
  logic              go_q;
  logic              start;
  logic              last;
  logic [ADDR_W-1:0] base_q;
  logic [ADDR_W-1:0] addr_q;
  th_word_t          count_q;
  th_word_t          left_q;
  logic              rd_valid_q;
  th_word_t          exp_q;
  th_word_t          rd_addr_q;

  assign ctrl_0 = ctrl_word(harness_control_i, REG_CTRL_0);
  assign count  = ctrl_word(harness_control_i, REG_CTRL_2);

  // Go edges are only taken when no run is active.
  assign start = ctrl_0[0] && !go_q && (state_q == IDLE || state_q == DONE);
  assign last  = (left_q == 16'd1);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q    <= IDLE;
      go_q       <= 1'b0;
      base_q     <= '0;
      addr_q     <= '0;
      count_q    <= '0;
      left_q     <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      go_q       <= ctrl_0[0];
      rd_valid_q <= (state_q == READ);  // Data returns one cycle later.
      case (state_q)
        IDLE, DONE: begin
          if (start) begin
            base_q  <= ADDR_W'(ctrl_word(harness_control_i, REG_CTRL_1));
            addr_q  <= ADDR_W'(ctrl_word(harness_control_i, REG_CTRL_1));
            count_q <= count;
            left_q  <= count;
            state_q <= (count == '0) ? DONE : WRITE;
          end
        end
        WRITE: begin
          if (last) begin
            addr_q  <= base_q;  // Second pass over the same window.
            left_q  <= count_q;
            state_q <= READ;
          end else begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
          end
        end
        READ: begin
          addr_q <= addr_q + 1'b1;
          left_q <= left_q - 1'b1;
          if (last) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          state_q <= DONE;  // Last compare happens here.
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // Expected word and address travel with the read in flight.
  always_ff @(posedge wb_clk_i) begin
    exp_q     <= pat_word_i;
    rd_addr_q <= pat_addr_o;
  end

  assign pat_restart_o = start || (state_q == WRITE && last);
  assign pat_step_o    = (state_q == WRITE) || (state_q == READ);
  assign pat_addr_o    = th_word_t'(addr_q);

  assign mem_we_o    = (state_q == WRITE);
  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = pat_word_i;

  assign cmp_valid_o = rd_valid_q;
  assign cmp_addr_o  = rd_addr_q;
  assign cmp_exp_o   = exp_q;
  assign cmp_act_o   = mem_rdata_i;

  assign clear_o = start;
  assign busy_o  = (state_q == WRITE) || (state_q == READ) || (state_q == DRAIN);
  assign done_o  = (state_q == DONE);

endmodule

/* src/th_result_log.sv */
`timescale 1ns/1ps

module th_result_log
  import th_pkg::*;
(
  input  logic     wb_clk_i,
  input  logic     wb_rst_i,
  input  logic     clear_i,
  input  logic     cmp_valid_i,
  input  th_word_t cmp_addr_i,
  input  th_word_t cmp_exp_i,
  input  th_word_t cmp_act_i,
  input  logic     busy_i,
  input  logic     done_i,
  input  th_ridx_t status_addr_i,
  output th_word_t status_o
);

  th_word_t err_cnt_q;
  th_word_t fail_addr_q;
  th_word_t fail_exp_q;
  th_word_t fail_act_q;
  th_word_t flags;
  logic     mismatch;

  assign mismatch = cmp_valid_i && (cmp_exp_i != cmp_act_i);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i || clear_i) begin
      err_cnt_q   <= '0;
      fail_addr_q <= '0;
      fail_exp_q  <= '0;
      fail_act_q  <= '0;
    end else if (mismatch) begin
      if (err_cnt_q != '1) begin
        err_cnt_q <= err_cnt_q + 1'b1;  // Saturates.
      end
      // A zero count means nothing has been captured yet.
      if (err_cnt_q == '0) begin
        fail_addr_q <= cmp_addr_i;
        fail_exp_q  <= cmp_exp_i;
        fail_act_q  <= cmp_act_i;
      end
    end
  end

  always_comb begin
    flags            = '0;
    flags[FLAG_BUSY] = busy_i;
    flags[FLAG_DONE] = done_i;
    flags[FLAG_PASS] = done_i && (err_cnt_q == '0);
  end

  always_comb begin
    case (status_addr_i)
      ST_FLAGS:     status_o = flags;
      ST_ERRCNT:    status_o = err_cnt_q;
      ST_FAIL_ADDR: status_o = fail_addr_q;
      ST_FAIL_EXP:  status_o = fail_exp_q;
      ST_FAIL_ACT:  status_o = fail_act_q;
      default:      status_o = '0;
    endcase
  end

endmodule

/* src/th_test_mem.sv */
`timescale 1ns/1ps

module th_test_mem
  import th_pkg::*;
#(
  parameter int unsigned ADDR_W = 8
) (
  input  logic              wb_clk_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  th_word_t          wdata_i,
  output th_word_t          rdata_o,
  input  logic              fault_en_i,
  input  th_word_t          fault_addr_i,
  input  th_word_t          fault_mask_i
);

  localparam int unsigned DEPTH = 2 ** ADDR_W;

  th_word_t mem_q [DEPTH];
  logic     fault_hit;

  // Full-width compare, so fault addresses past the top never alias.
  assign fault_hit = fault_en_i && (th_word_t'(addr_i) == fault_addr_i);

  always_ff @(posedge wb_clk_i) begin
    if (we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i] ^ (fault_hit ? fault_mask_i : th_word_t'(0));
  end

endmodule

/* src/th_top.sv */
`timescale 1ns/1ps

module th_top
  import th_pkg::*;
#(
  parameter int unsigned ADDR_W = 8
) (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_we_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  th_word_t    wb_dat_i,
  output th_word_t    wb_dat_o,
  output logic        wb_ack_o
);

  th_ctrl_t          harness_control;
  th_ridx_t          status_addr;
  th_word_t          harness_status;
  th_word_t          ctrl_0;
  th_word_t          ctrl_6;
  th_mode_t          mode;
  logic              pat_restart;
  logic              pat_step;
  th_word_t          pat_addr;
  th_word_t          pat_word;
  logic              mem_we;
  logic [ADDR_W-1:0] mem_addr;
  th_word_t          mem_wdata;
  th_word_t          mem_rdata;
  logic              cmp_valid;
  th_word_t          cmp_addr;
  th_word_t          cmp_exp;
  th_word_t          cmp_act;
  logic              clear;
  logic              busy;
  logic              done;

  assign ctrl_0 = ctrl_word(harness_control, REG_CTRL_0);
  assign ctrl_6 = ctrl_word(harness_control, REG_CTRL_6);
  assign mode   = th_mode_t'(ctrl_0[2:1]);

  th_wb_regs u_regs (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .wb_we_i           (wb_we_i),
    .wb_cyc_i          (wb_cyc_i),
    .wb_stb_i          (wb_stb_i),
    .wb_sel_i          (wb_sel_i),
    .wb_adr_i          (wb_adr_i),
    .wb_dat_i          (wb_dat_i),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_o          (wb_ack_o),
    .status_addr_o     (status_addr),
    .harness_status_i  (harness_status),
    .harness_control_o (harness_control)
  );

  th_sequencer #(.ADDR_W(ADDR_W)) u_seq (
    .wb_clk_i          (wb_clk_i),
    .wb_rst_i          (wb_rst_i),
    .harness_control_i (harness_control),
    .pat_restart_o     (pat_restart),
    .pat_step_o        (pat_step),
    .pat_addr_o        (pat_addr),
    .pat_word_i        (pat_word),
    .mem_we_o          (mem_we),
    .mem_addr_o        (mem_addr),
    .mem_wdata_o       (mem_wdata),
    .mem_rdata_i       (mem_rdata),
    .cmp_valid_o       (cmp_valid),
    .cmp_addr_o        (cmp_addr),
    .cmp_exp_o         (cmp_exp),
    .cmp_act_o         (cmp_act),
    .clear_o           (clear),
    .busy_o            (busy),
    .done_o            (done)
  );

  th_pattern_gen u_pat (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .restart_i (pat_restart),
    .step_i    (pat_step),
    .mode_i    (mode),
    .seed_i    (ctrl_word(harness_control, REG_CTRL_3)),
    .addr_i    (pat_addr),
    .word_o    (pat_word)
  );

  th_test_mem #(.ADDR_W(ADDR_W)) u_mem (
    .wb_clk_i     (wb_clk_i),
    .we_i         (mem_we),
    .addr_i       (mem_addr),
    .wdata_i      (mem_wdata),
    .rdata_o      (mem_rdata),
    .fault_en_i   (ctrl_6[0]),
    .fault_addr_i (ctrl_word(harness_control, REG_CTRL_4)),
    .fault_mask_i (ctrl_word(harness_control, REG_CTRL_5))
  );

  th_result_log u_log (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .clear_i       (clear),
    .cmp_valid_i   (cmp_valid),
    .cmp_addr_i    (cmp_addr),
    .cmp_exp_i     (cmp_exp),
    .cmp_act_i     (cmp_act),
    .busy_i        (busy),
    .done_i        (done),
    .status_addr_i (status_addr),
    .status_o      (harness_status)
  );

endmodule

/* dv/th_assertions.sv */
`timescale 1ns/1ps

module th_assertions (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic ack_i,
  input logic clear_i,
  input logic miss_i,
  input logic done_i,
  input logic pass_i
);

  int unsigned fails = 0;
  logic        miss_seen_q;  // Some compare went wrong in this run.

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      miss_seen_q <= 1'b0;
    end else if (miss_i) begin
      miss_seen_q <= 1'b1;
    end
  end

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
    else begin
      fails++;
      $error("ack stayed high for more than one cycle");
    end

  ack_after_req: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |-> $past(req_i))
    else begin
      fails++;
      $error("ack without a preceding cyc and stb");
    end

  // Done with no mismatch must report pass, any mismatch must block it.
  pass_on_clean_done: assert property (@(posedge clk_i) disable iff (rst_i)
                                       done_i |-> (pass_i == !miss_seen_q))
    else begin
      fails++;
      $error("pass flag disagrees with the compares seen in the run");
    end

endmodule

bind th_wb_regs th_assertions u_wb_chk (.clk_i(wb_clk_i), .rst_i(wb_rst_i),
  .req_i(wb_cyc_i && wb_stb_i), .ack_i(wb_ack_o), .clear_i(1'b0), .miss_i(1'b0),
  .done_i(1'b0), .pass_i(1'b0));

bind th_result_log th_assertions u_log_chk (.clk_i(wb_clk_i), .rst_i(wb_rst_i),
  .req_i(1'b0), .ack_i(1'b0), .clear_i(clear_i),
  .miss_i(cmp_valid_i && cmp_exp_i != cmp_act_i), .done_i(done_i),
  .pass_i(flags[FLAG_PASS]));

/* dv/th_tb.sv */
`timescale 1ns/1ps

module th_tb
  import th_pkg::*;
();

  localparam int unsigned ADDR_W  = 8;
  localparam int unsigned DEPTH   = 2 ** ADDR_W;
  localparam int unsigned TIMEOUT = 1000;

  logic        wb_clk_i, wb_rst_i, wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  th_word_t    wb_dat_i, wb_dat_o;
  th_word_t    rd;                 // Data of the last bus read.
  th_word_t    ctrl_m [NUM_CTRL];  // Expected control words.
  logic [31:0] rnd_q;
  int unsigned errors, test_errs, tests, bad_tests;

  th_top #(.ADDR_W(ADDR_W)) uut (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #50 wb_clk_i = ~wb_clk_i;
  end

  // One LFSR step per stimulus bit.
  function automatic int unsigned rand_bits(int unsigned n);
    int unsigned v;
    v = 0;
    repeat (n) begin
      rnd_q = (rnd_q >> 1) ^ (rnd_q[0] ? 32'h8020_0003 : 32'h0);
      v = (v << 1) | rnd_q[0];
    end
    return v;
  endfunction

  // Word k of a run, k counted from the base.
  function automatic th_word_t expected_word(th_mode_t mode, th_word_t seed, th_word_t base,
                                             int k);
    th_word_t a;
    th_word_t s;
    a = th_word_t'((base + k) % DEPTH);
    s = seed;
    repeat (k) s = (s >> 1) ^ (s[0] ? LFSR_TAPS : 16'h0);
    case (mode)
      MODE_ADDR: return a ^ seed;
      MODE_LFSR: return s;
      MODE_WALK: return 16'h1 << a[3:0];
      default:   return seed;
    endcase
  endfunction

  task automatic stop_on_timeout(string what);
    $display("Timeout: %s", what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic check(string name, th_word_t exp, th_word_t act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic end_test(string name);
    tests++;
    if (test_errs != 0) bad_tests++;
    $display("%-16s %s", name, (test_errs == 0) ? "ok" : "mismatch");
    test_errs = 0;
  endtask

  task automatic wb_access(logic we, th_ridx_t idx, th_word_t data, logic [1:0] sel);
    int unsigned n;
    {wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i} = {2'b11, we, sel};
    wb_adr_i = {10'b0, idx, 1'b0};
    wb_dat_i = data;
    n = 0;
    do begin
      @(negedge wb_clk_i);
      n++;
      if (n > TIMEOUT) stop_on_timeout("no Wishbone ack came back");
    end while (!wb_ack_o);
    rd = wb_dat_o;  // Sampled mid-cycle under ack.
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
  endtask

  task automatic run_test(string name, th_mode_t mode, th_word_t base, th_word_t count,
                          th_word_t seed, th_word_t f_addr, th_word_t f_mask, logic regoes);
    th_word_t    w [NUM_CTRL];
    th_word_t    exp_st [5];
    int          hit;
    int unsigned n;
    hit = count;  // Window index of the faulty word, count if none.
    for (int k = count - 1; k >= 0; k--) begin
      if (f_mask != 0 && th_word_t'((base + k) % DEPTH) == f_addr) hit = k;
    end
    w = '{{13'b0, mode, 1'b0}, base, count, seed, f_addr, f_mask, 16'(f_mask != 0)};
    for (int i = NUM_CTRL - 1; i >= 0; i--) wb_access(1'b1, th_ridx_t'(i), w[i], 2'b11);
    wb_access(1'b1, REG_CTRL_0, w[0] | 16'h1, 2'b11);  // Go edge.
    if (regoes) begin
      wb_access(1'b1, REG_CTRL_2, 16'd1, 2'b11);  // A restart would miss the fault.
      wb_access(1'b1, REG_CTRL_0, w[0], 2'b11);
      wb_access(1'b1, REG_CTRL_0, w[0] | 16'h1, 2'b11);
      wb_access(1'b0, ST_FLAGS, 16'h0, 2'b11);
      check({name, " busy"}, 16'h0001, rd);
    end
    n = 0;
    do begin
      wb_access(1'b0, ST_FLAGS, 16'h0, 2'b11);
      n++;
      if (n > TIMEOUT) stop_on_timeout({name, " never set done"});
    end while (!rd[FLAG_DONE]);
    exp_st[1] = th_word_t'(hit < count);
    exp_st[0] = exp_st[1] ? 16'h0002 : 16'h0006;
    exp_st[2] = exp_st[1] ? f_addr : 16'h0;
    exp_st[3] = exp_st[1] ? expected_word(mode, seed, base, hit) : 16'h0;
    exp_st[4] = exp_st[3] ^ (exp_st[1] ? f_mask : 16'h0);
    for (int j = 0; j < 5; j++) begin
      wb_access(1'b0, ST_FLAGS + th_ridx_t'(j), 16'h0, 2'b11);
      check($sformatf("%s status %0d", name, 8 + j), exp_st[j], rd);
    end
    end_test(name);
  endtask

  initial begin
    th_word_t b, c, d, fa;
    wb_rst_i = 1'b1;
    {wb_we_i, wb_cyc_i, wb_stb_i, wb_sel_i, wb_adr_i, wb_dat_i} = '0;
    rnd_q = 32'd78013;
    {errors, test_errs, tests, bad_tests} = '0;
    ctrl_m = '{default: 16'h0};
    repeat (2) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    for (int i = 0; i <= ST_FAIL_ACT; i++) begin
      wb_access(1'b0, th_ridx_t'(i), 16'h0, 2'b11);
      check($sformatf("reset index %0d", i), 16'h0, rd);
    end
    end_test("reset values");

    // Full write first, then each lane alone, then none.
    for (int i = 0; i < NUM_CTRL; i++) begin
      for (int s = 3; s >= 0; s--) begin
        d = th_word_t'(rand_bits(16)) & ((i == 0) ? 16'hfffe : 16'hffff);  // Go stays low.
        wb_access(1'b1, th_ridx_t'(i), d, 2'(s));
        if (s[0]) ctrl_m[i][7:0] = d[7:0];
        if (s[1]) ctrl_m[i][15:8] = d[15:8];
      end
    end
    for (int i = 0; i < NUM_CTRL; i++) begin
      wb_access(1'b0, th_ridx_t'(i), 16'h0, 2'b11);
      check($sformatf("ctrl %0d", i), ctrl_m[i], rd);
    end
    end_test("byte lanes");

    for (int m = 0; m < 4; m++) begin
      b = th_word_t'(rand_bits(8));
      c = th_word_t'(1 + rand_bits(7));
      run_test($sformatf("mode %0d run", m), th_mode_t'(m), b, c, th_word_t'(rand_bits(16)),
               16'h0, 16'h0, 1'b0);
    end
    for (int m = 0; m < 4; m++) begin
      b  = th_word_t'(rand_bits(8));
      c  = th_word_t'(2 + rand_bits(7));
      d  = th_word_t'(rand_bits(16));
      fa = th_word_t'((b + rand_bits(7) % c) % DEPTH);
      run_test($sformatf("fault mode %0d", m), th_mode_t'(m), b, c, d, fa,
               th_word_t'(rand_bits(16)) | 16'h1, 1'b0);
    end
    run_test("fault outside", MODE_ADDR, 16'd16, 16'd32, 16'h5a5a, 16'd100, 16'h00ff, 1'b0);
    // 0x110 lies past the top address and must not alias onto 0x10.
    run_test("window wrap", MODE_LFSR, 16'd240, 16'd40, 16'h1234, 16'h0110, 16'h8001, 1'b0);
    // Fault on the last word of the window, so only the full run sees it.
    b = th_word_t'(rand_bits(8));
    run_test("go while busy", MODE_WALK, b, 16'd200, 16'h0, th_word_t'((b + 199) % DEPTH),
             16'h0100, 1'b1);

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures", tests,
             bad_tests, errors, uut.u_regs.u_wb_chk.fails + uut.u_log.u_log_chk.fails);
    if (errors == 0 && uut.u_regs.u_wb_chk.fails == 0 && uut.u_log.u_log_chk.fails == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* list.f */
src/th_pkg.sv
src/th_wb_regs.sv
src/th_pattern_gen.sv
src/th_sequencer.sv
src/th_result_log.sv
src/th_test_mem.sv
src/th_top.sv
dv/th_assertions.sv
dv/th_tb.sv

/* Bender.yml */
package:
  name: th_harness

sources:
  - files:
      - src/th_pkg.sv
      - src/th_wb_regs.sv
      - src/th_pattern_gen.sv
      - src/th_sequencer.sv
      - src/th_result_log.sv
      - src/th_test_mem.sv
      - src/th_top.sv
  - target: test
    files:
      - dv/th_assertions.sv
      - dv/th_tb.sv
